// File: build.f
+incdir+design
design/rv_pkg.sv
design/axi_pkg.sv
design/load_extend.sv
design/lsu_stage.sv
design/axi_sram.sv
design/lsu_top.sv
tests/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build the load/store stage testbench with Verilator, run it, and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f build.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation clean"

// File: tests/lsu_tb.sv
// testbench for lsu_top; drives ops against a reference memory and checks each writeback result

`include "lsu_config.svh"

module lsu_tb;
    import rv_pkg::*;

    localparam int drive_dly   = 1;
    localparam int n_pass      = 20;
    localparam int n_word      = 16;
    localparam int n_lane      = 4;
    localparam int n_ext       = 4;
    localparam int n_oob       = 8;
    localparam int n_rand      = 200;
    localparam int n_ops       = n_pass + 2 * n_word + 13 * n_lane + 17 * n_ext
                                 + 3 * n_oob + n_rand;
    localparam int cycle_limit = n_ops * 12 + 100;

    logic       clock;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    ex_to_lsu_t in_op;
    logic       out_valid;
    logic       out_ready;
    lsu_to_wb_t out_wb;

    word_t      ref_mem [`LSU_MEM_WORDS];
    lsu_to_wb_t exp_q [$];
    integer     seed = 32'h753146c5;
    integer     ready_seed = 32'h753146c5;  // own stream for back-pressure
    logic       throttle;
    int         cycles = 0;
    int         check_count = 0;
    int         error_count = 0;
    int         test_num = 0;
    int         test_err_base = 0;

    lsu_top dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_wb    (out_wb)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // expected extension of a loaded word
    function automatic word_t extend_ref(word_t w, logic [1:0] off, mem_funct_t f);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8 * off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (f)
            mem_b:   return {{24{b[7]}}, b};
            mem_h:   return {{16{h[15]}}, h};
            mem_w:   return w;
            mem_bu:  return {24'h0, b};
            mem_hu:  return {16'h0, h};
            default: return '0;
        endcase
    endfunction

    // predicts writeback and updates the model memory for in-range stores
    function automatic lsu_to_wb_t predict_wb(ex_to_lsu_t op);
        lsu_to_wb_t             wb;
        logic                   in_range;
        logic [`LSU_MEM_AW-1:0] idx;
        in_range     = (op.addr >> 2) < `LSU_MEM_WORDS;
        idx          = op.addr[`LSU_MEM_AW+1:2];
        wb.rd        = op.rd;
        wb.rd_write  = op.rd_write;
        wb.result    = op.rd_value;
        wb.bus_error = 1'b0;
        if (op.is_load) begin
            wb.bus_error = !in_range;
            wb.result    = in_range ? extend_ref(ref_mem[idx], op.addr[1:0], op.funct) : '0;
        end else if (op.is_store) begin
            wb.bus_error = !in_range;
            if (in_range) begin
                case (op.funct)
                    mem_b:   ref_mem[idx][8 * op.addr[1:0] +: 8] = op.store_data[7:0];
                    mem_h:   ref_mem[idx][16 * op.addr[1] +: 16] = op.store_data[15:0];
                    mem_w:   ref_mem[idx] = op.store_data;
                    default: ;
                endcase
            end
        end
        return wb;
    endfunction

    function automatic ex_to_lsu_t make_op(logic ld, logic st, mem_funct_t f, word_t addr,
                                           word_t data);
        ex_to_lsu_t op;
        word_t      rnd;
        rnd           = rand_word();
        op.is_load    = ld;
        op.is_store   = st;
        op.funct      = f;
        op.addr       = addr;
        op.store_data = data;
        op.rd         = rnd[4:0];
        op.rd_write   = rnd[5];
        op.rd_value   = rand_word();
        return op;
    endfunction

    function automatic ex_to_lsu_t random_op();
        mem_funct_t ld_f [5] = '{mem_b, mem_h, mem_w, mem_bu, mem_hu};
        mem_funct_t st_f [3] = '{mem_b, mem_h, mem_w};
        word_t      kind;
        word_t      addr;
        kind = rand_word() % 3;
        addr = rand_word() & 32'h0000_0fff;
        if (rand_word() % 8 == 0)
            addr = addr | 32'h0001_0000;  // beyond the memory
        if (kind == 0)
            return make_op(1'b1, 1'b0, ld_f[rand_word() % 5], addr, '0);
        else if (kind == 1)
            return make_op(1'b0, 1'b1, st_f[rand_word() % 3], addr, rand_word());
        return make_op(1'b0, 1'b0, mem_w, addr, rand_word());
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // starts and ends just after a rising edge
    task automatic send_op(input ex_to_lsu_t op);
        exp_q.push_back(predict_wb(op));
        in_op    = op;
        in_valid = 1'b1;
        do
            @(negedge clock);
        while (!in_ready);
        @(posedge clock);
        #drive_dly;
        in_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge clock);
            #drive_dly;
        end
        if (out_valid) begin
            $display("the DUT still offers a result after the last expected one");
            error_count++;
        end
        test_num++;
        $display("test %0d %-24s errors %0d", test_num, name, error_count - test_err_base);
        test_err_base = error_count;
    endtask

    task automatic run_word_rw();
        word_t addrs [n_word];
        for (int i = 0; i < n_word; i++) begin
            addrs[i] = rand_word() & 32'h0000_0ffc;
            send_op(make_op(1'b0, 1'b1, mem_w, addrs[i], rand_word()));
        end
        for (int i = 0; i < n_word; i++)
            send_op(make_op(1'b1, 1'b0, mem_w, addrs[i], '0));
    endtask

    // every narrow store is followed by a word load of the whole word
    task automatic run_lanes();
        word_t addr;
        for (int i = 0; i < n_lane; i++) begin
            addr = rand_word() & 32'h0000_0ffc;
            send_op(make_op(1'b0, 1'b1, mem_w, addr, rand_word()));
            for (int off = 0; off < 4; off++) begin
                send_op(make_op(1'b0, 1'b1, mem_b, addr + off, rand_word()));
                send_op(make_op(1'b1, 1'b0, mem_w, addr, '0));
            end
            for (int off = 0; off < 4; off += 2) begin
                send_op(make_op(1'b0, 1'b1, mem_h, addr + off, rand_word()));
                send_op(make_op(1'b1, 1'b0, mem_w, addr, '0));
            end
        end
    endtask

    task automatic run_extend();
        word_t addr;
        for (int i = 0; i < n_ext; i++) begin
            addr = rand_word() & 32'h0000_0ffc;
            send_op(make_op(1'b0, 1'b1, mem_w, addr, rand_word()));
            for (int off = 0; off < 4; off++) begin
                send_op(make_op(1'b1, 1'b0, mem_b, addr + off, '0));
                send_op(make_op(1'b1, 1'b0, mem_bu, addr + off, '0));
                send_op(make_op(1'b1, 1'b0, mem_h, addr + off, '0));
                send_op(make_op(1'b1, 1'b0, mem_hu, addr + off, '0));
            end
        end
    endtask

    task automatic run_out_of_range();
        word_t addr;
        for (int i = 0; i < n_oob; i++) begin
            addr = (rand_word() & 32'h00ff_fffc) | 32'h0000_1000;
            send_op(make_op(1'b0, 1'b1, mem_w, addr, rand_word()));
            send_op(make_op(1'b1, 1'b0, mem_w, addr, '0));
            send_op(make_op(1'b1, 1'b0, mem_w, addr & 32'h0000_0ffc, '0));  // aliased word
        end
    endtask

    // back-pressure toggles only while throttle is set
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clock);
            #drive_dly;
            out_ready = throttle ? ($random(ready_seed) & 1) != 0 : !reset;
        end
    end

    // results transfer on the next rising edge
    always @(negedge clock) begin
        lsu_to_wb_t expected;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("the DUT produced a result with no operation pending");
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                check_reg_idx("out_wb.rd", out_wb.rd, expected.rd);
                check_flag("out_wb.rd_write", out_wb.rd_write, expected.rd_write);
                check_word("out_wb.result", out_wb.result, expected.result);
                check_flag("out_wb.bus_error", out_wb.bus_error, expected.bus_error);
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run did not finish within %0d cycles, %0d results missing",
                     cycle_limit, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = '0;
        throttle = 1'b0;
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            ref_mem[i] = '0;
        repeat (4) @(posedge clock);
        #drive_dly;
        reset = 1'b0;

        for (int i = 0; i < n_pass; i++)
            send_op(make_op(1'b0, 1'b0, mem_w, rand_word(), rand_word()));
        finish_test("pass-through");
        run_word_rw();
        finish_test("word store/load");
        run_lanes();
        finish_test("byte/half lanes");
        run_extend();
        finish_test("load extension");
        run_out_of_range();
        finish_test("out of range");

        @(negedge clock);
        throttle = 1'b1;
        @(posedge clock);
        #drive_dly;
        for (int i = 0; i < n_rand; i++)
            send_op(random_op());
        finish_test("random back-pressure");

        $display("%0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: design/lsu_top.sv
// load/store stage wired to its AXI4 memory; the pipeline-side ports face execute and writeback

module lsu_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  rv_pkg::ex_to_lsu_t  in_op,
    output logic                out_valid,
    input  logic                out_ready,
    output rv_pkg::lsu_to_wb_t  out_wb
);
    import axi_pkg::*;

    logic      awvalid, awready;
    logic      wvalid, wready;
    logic      bvalid, bready;
    logic      arvalid, arready;
    logic      rvalid, rready;
    axi_addr_t aw;
    axi_addr_t ar;
    axi_w_t    w;
    axi_resp_t bresp;
    axi_r_t    r;

    lsu_stage lsu_stage_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_wb    (out_wb),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    axi_sram axi_sram_i (
        .clock   (clock),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

endmodule

// File: design/axi_sram.sv
// single-beat AXI4 slave memory with byte strobes; out-of-range accesses get slverr

`include "lsu_config.svh"

module axi_sram (
    input  logic                clock,
    input  logic                reset,

    input  logic                awvalid,
    output logic                awready,
    input  axi_pkg::axi_addr_t  aw,

    input  logic                wvalid,
    output logic                wready,
    input  axi_pkg::axi_w_t     w,

    output logic                bvalid,
    input  logic                bready,
    output axi_pkg::axi_resp_t  bresp,

    input  logic                arvalid,
    output logic                arready,
    input  axi_pkg::axi_addr_t  ar,

    output logic                rvalid,
    input  logic                rready,
    output axi_pkg::axi_r_t     r
);
    import axi_pkg::*;

    axi_data_t mem [`LSU_MEM_WORDS];

    logic                   aw_held;
    logic                   w_held;
    axi_addr_t              aw_q;
    axi_w_t                 w_q;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   ar_fire;
    logic                   wr_go;
    axi_addr_t              wr_addr;
    axi_w_t                 wr_beat;
    logic                   wr_in_range;
    logic                   rd_in_range;
    logic [`LSU_MEM_AW-1:0] wr_idx;
    logic [`LSU_MEM_AW-1:0] rd_idx;

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // aw and w may arrive in either order
    assign wr_addr = aw_held ? aw_q : aw;
    assign wr_beat = w_held ? w_q : w;
    assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire);

    assign wr_idx      = wr_addr.addr[`LSU_MEM_AW+1:2];
    assign rd_idx      = ar.addr[`LSU_MEM_AW+1:2];
    assign wr_in_range = wr_addr.addr[`LSU_XLEN-1:2] < `LSU_MEM_WORDS;
    assign rd_in_range = ar.addr[`LSU_XLEN-1:2] < `LSU_MEM_WORDS;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (aw_fire)
                    aw_held <= 1'b1;
                if (w_fire)
                    w_held <= 1'b1;
                if (bvalid && bready)
                    bvalid <= 1'b0;
            end
            if (ar_fire)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire)
            aw_q <= aw;
        if (w_fire)
            w_q <= w;
        if (wr_go)
            bresp <= wr_in_range ? resp_okay : resp_slverr;
        if (ar_fire)
            r <= '{data: rd_in_range ? mem[rd_idx] : '0,
                   resp: rd_in_range ? resp_okay : resp_slverr};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (wr_go && wr_in_range) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (wr_beat.strb[b])
                    mem[wr_idx][8*b +: 8] <= wr_beat.data[8*b +: 8];
            end
        end
    end

endmodule

// File: design/lsu_stage.sv
// load/store pipeline stage; takes one op from execute, runs it over AXI4 and hands the result on

module lsu_stage (
    input  logic                clock,
    input  logic                reset,

    input  logic                in_valid,
    output logic                in_ready,
    input  rv_pkg::ex_to_lsu_t  in_op,

    output logic                out_valid,
    input  logic                out_ready,
    output rv_pkg::lsu_to_wb_t  out_wb,

    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::axi_addr_t  aw,

    output logic                wvalid,
    input  logic                wready,
    output axi_pkg::axi_w_t     w,

    input  logic                bvalid,
    output logic                bready,
    input  axi_pkg::axi_resp_t  bresp,

    output logic                arvalid,
    input  logic                arready,
    output axi_pkg::axi_addr_t  ar,

    input  logic                rvalid,
    output logic                rready,
    input  axi_pkg::axi_r_t     r
);
    import rv_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_hold
    } lsu_state_t;

    lsu_state_t state;
    ex_to_lsu_t op_q;
    lsu_to_wb_t wb_q;
    word_t      load_word;
    logic [1:0] byte_off;
    logic       accept;
    logic       is_mem;
    logic       r_fire;
    logic       b_fire;
    axi_size_t  xfer_size;
    axi_data_t  store_data;
    axi_strb_t  store_strb;
    axi_addr_t  req_addr;

    assign in_ready  = (state == st_idle) || (state == st_hold && out_ready);
    assign accept    = in_valid && in_ready;
    assign is_mem    = in_op.is_load || in_op.is_store;
    assign r_fire    = rvalid && rready;
    assign b_fire    = bvalid && bready;
    assign out_valid = (state == st_hold);
    assign out_wb    = wb_q;
    assign byte_off  = op_q.addr[1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            if (accept) begin
                state   <= is_mem ? st_wait : st_hold;
                arvalid <= in_op.is_load;
                rready  <= in_op.is_load;
                awvalid <= in_op.is_store && !in_op.is_load;  // load wins if both set
                wvalid  <= in_op.is_store && !in_op.is_load;
                bready  <= in_op.is_store && !in_op.is_load;
            end else begin
                if (r_fire || b_fire)
                    state <= st_hold;
                else if (state == st_hold && out_ready)
                    state <= st_idle;
                if (arvalid && arready)
                    arvalid <= 1'b0;
                if (r_fire)
                    rready <= 1'b0;
                if (awvalid && awready)
                    awvalid <= 1'b0;
                if (wvalid && wready)
                    wvalid <= 1'b0;
                if (b_fire)
                    bready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept)
            op_q <= in_op;
        if (accept && !is_mem)
            wb_q <= '{rd: in_op.rd, rd_write: in_op.rd_write, result: in_op.rd_value,
                      bus_error: 1'b0};
        else if (r_fire)
            wb_q <= '{rd: op_q.rd, rd_write: op_q.rd_write, result: load_word,
                      bus_error: (r.resp == resp_slverr)};
        else if (b_fire)
            wb_q <= '{rd: op_q.rd, rd_write: op_q.rd_write, result: op_q.rd_value,
                      bus_error: (bresp == resp_slverr)};
    end

    // store lanes follow the low address bits
    always_comb begin
        store_data = op_q.store_data;
        store_strb = '0;
        case (op_q.funct)
            mem_b: begin
                store_data = op_q.store_data << {byte_off, 3'b000};
                store_strb = 4'b0001 << byte_off;
            end
            mem_h: begin
                store_data = op_q.store_data << {byte_off[1], 4'b0000};
                store_strb = 4'b0011 << {byte_off[1], 1'b0};
            end
            mem_w: store_strb = '1;
            default: store_strb = '0;
        endcase
    end

    always_comb begin
        case (op_q.funct)
            mem_b, mem_bu: xfer_size = size_byte;
            mem_h, mem_hu: xfer_size = size_half;
            default:       xfer_size = size_word;
        endcase
    end

    assign req_addr = '{addr: op_q.addr, size: xfer_size};
    assign aw       = req_addr;
    assign ar       = req_addr;
    assign w        = '{data: store_data, strb: store_strb};

    load_extend load_extend_i (
        .word   (r.data),
        .offset (byte_off),
        .funct  (op_q.funct),
        .result (load_word)
    );

endmodule

// File: design/load_extend.sv
// picks the addressed byte or halfword of a read word and extends it by funct3

`include "lsu_config.svh"

module load_extend (
    input  rv_pkg::word_t       word,
    input  logic [1:0]          offset,
    input  rv_pkg::mem_funct_t  funct,
    output rv_pkg::word_t       result
);
    import rv_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[{offset, 3'b000} +: 8];
    assign half_sel = word[{offset[1], 4'b0000} +: 16];  // bit 0 of offset ignored

    always_comb begin
        case (funct)
            mem_b: begin
                result = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
            end
            mem_h: begin
                result = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
            end
            mem_w: begin
                result = word;
            end
            mem_bu: begin
                result = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
            end
            mem_hu: begin
                result = {{(`LSU_XLEN-16){1'b0}}, half_sel};
            end
            default: begin
                result = '0;  // invalid funct3
            end
        endcase
    end

endmodule

// File: design/axi_pkg.sv
// AXI4 channel payload types for the single-beat memory port; import where used

`include "lsu_config.svh"

package axi_pkg;

    typedef logic [`LSU_XLEN-1:0] axi_data_t;
    typedef logic [`LSU_XLEN/8-1:0] axi_strb_t;
    typedef logic [2:0] axi_size_t;

    localparam axi_size_t size_byte = 3'd0;
    localparam axi_size_t size_half = 3'd1;
    localparam axi_size_t size_word = 3'd2;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // shared by aw and ar
    typedef struct packed {
        axi_data_t addr;
        axi_size_t size;
    } axi_addr_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

endpackage

// File: design/rv_pkg.sv
// pipeline-side types shared by execute, the load/store stage and writeback; import where used

`include "lsu_config.svh"

package rv_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // funct3 of loads and stores with 3'b011/110/111 left invalid
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_funct_t;

    typedef struct packed {
        logic       is_load;
        logic       is_store;
        mem_funct_t funct;
        word_t      addr;       // alu result
        word_t      store_data;
        reg_idx_t   rd;
        logic       rd_write;
        word_t      rd_value;
    } ex_to_lsu_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     rd_write;
        word_t    result;     // extended load data or rd_value
        logic     bus_error;
    } lsu_to_wb_t;

endpackage

// File: design/lsu_config.svh
// width and depth settings for the load/store stage and its memory; include before the packages

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_XLEN 32

// memory depth in words, and the matching word index width
`define LSU_MEM_WORDS 1024
`define LSU_MEM_AW 10

`endif
